/* rtl/soc_pkg.sv */
// Address map and widths are fixed here and every RTL module depends on them
`default_nettype none

package soc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);
  localparam int unsigned L2NumWords   = 512;
  localparam int unsigned L2IdxWidth   = $clog2(L2NumWords);
  // Control register offset bits within its 4 KiB window
  localparam int unsigned RegOffWidth  = 12;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map

  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = StrbWidth * L2NumWords;
  localparam logic [AddrWidth-1:0] UartBase   = 32'hC000_0000;
  localparam logic [AddrWidth-1:0] UartLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] CtrlBase   = 32'hD000_0000;
  localparam logic [AddrWidth-1:0] CtrlLength = 32'h0000_1000;

  ////////////////////////////////////////////////////////////////////////////
  // Bus types

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  typedef enum logic [RegOffWidth-1:0] {
    REG_EXIT      = 12'h000,
    REG_CNT_EN    = 12'h008,
    REG_DRAM_BASE = 12'h010,
    REG_DRAM_END  = 12'h018
  } ctrl_reg_e;

endpackage

`default_nettype wire

/* rtl/soc_addr_decoder.sv */
// Single master with one transaction in flight and responses returned strictly in order
`timescale 1ns/1ps
`default_nettype none

module soc_addr_decoder (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  soc_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output soc_pkg::bus_req_t tgt_req_o,
  output logic              l2_valid_o,
  input  logic              l2_ready_i,
  input  logic              l2_done_i,
  input  soc_pkg::bus_rsp_t l2_rsp_i,
  output logic              uart_valid_o,
  input  logic              uart_ready_i,
  input  logic              uart_done_i,
  input  soc_pkg::bus_rsp_t uart_rsp_i,
  output logic              ctrl_valid_o,
  input  logic              ctrl_ready_i,
  input  logic              ctrl_done_i,
  input  soc_pkg::bus_rsp_t ctrl_rsp_i
);

  soc_pkg::target_e  tgt_sel;
  logic              tgt_ready;
  logic              busy_q;
  logic              rsp_valid_q;
  soc_pkg::bus_rsp_t rsp_q;
  logic              req_accept;
  logic              err_accept;
  logic              any_done;

  function automatic logic in_region(input logic [soc_pkg::AddrWidth-1:0] addr,
                                     input logic [soc_pkg::AddrWidth-1:0] base,
                                     input logic [soc_pkg::AddrWidth-1:0] len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Address decode

  always_comb begin
    tgt_sel = soc_pkg::TGT_NONE;
    if (in_region(req_i.addr, soc_pkg::DramBase, soc_pkg::DramLength))
      tgt_sel = soc_pkg::TGT_L2;
    else if (in_region(req_i.addr, soc_pkg::UartBase, soc_pkg::UartLength))
      tgt_sel = soc_pkg::TGT_UART;
    else if (in_region(req_i.addr, soc_pkg::CtrlBase, soc_pkg::CtrlLength))
      tgt_sel = soc_pkg::TGT_CTRL;
  end

  always_comb begin
    case (tgt_sel)
      soc_pkg::TGT_L2:   tgt_ready = l2_ready_i;
      soc_pkg::TGT_UART: tgt_ready = uart_ready_i;
      soc_pkg::TGT_CTRL: tgt_ready = ctrl_ready_i;
      default:           tgt_ready = 1'b1;
    endcase
  end

  assign req_ready_o  = !busy_q && tgt_ready;
  assign req_accept   = req_valid_i && req_ready_o;
  assign err_accept   = req_accept && (tgt_sel == soc_pkg::TGT_NONE);
  assign any_done     = l2_done_i || uart_done_i || ctrl_done_i;
  assign tgt_req_o    = req_i;
  assign l2_valid_o   = req_valid_i && !busy_q && (tgt_sel == soc_pkg::TGT_L2);
  assign uart_valid_o = req_valid_i && !busy_q && (tgt_sel == soc_pkg::TGT_UART);
  assign ctrl_valid_o = req_valid_i && !busy_q && (tgt_sel == soc_pkg::TGT_CTRL);

  ////////////////////////////////////////////////////////////////////////////
  // Response buffer

  // Busy until the buffered response leaves
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_accept)
        busy_q <= 1'b1;
      else if (rsp_valid_q && rsp_ready_i)
        busy_q <= 1'b0;
      if (err_accept || any_done)
        rsp_valid_q <= 1'b1;
      else if (rsp_ready_i)
        rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_accept)
      rsp_q <= '{rdata: '0, err: 1'b1};
    else if (l2_done_i)
      rsp_q <= l2_rsp_i;
    else if (uart_done_i)
      rsp_q <= uart_rsp_i;
    else if (ctrl_done_i)
      rsp_q <= ctrl_rsp_i;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i));
  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));
  a_no_idle_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !busy_q |-> !any_done);

endmodule

`default_nettype wire

/* rtl/l2_mem.sv */
// Contents are not initialized so a read of a word never written returns X
`timescale 1ns/1ps
`default_nettype none

module l2_mem (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  output logic              ready_o,
  output logic              done_o,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  logic [soc_pkg::DataWidth-1:0]  mem_q [soc_pkg::L2NumWords];
  logic [soc_pkg::DataWidth-1:0]  rdata_q;
  logic [soc_pkg::L2IdxWidth-1:0] word_idx;
  logic                           done_q;

  assign word_idx = req_i.addr[soc_pkg::ByteOffWidth +: soc_pkg::L2IdxWidth];

  // Strobed write or registered read
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (req_i.write) begin
        for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
          if (req_i.strb[b])
            mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      done_q <= 1'b0;
    else
      done_q <= valid_i;
  end

  // Never stalls
  assign ready_o = 1'b1;
  assign done_o  = done_q;
  assign rsp_o   = '{rdata: rdata_q, err: 1'b0};

  // Decoder routes only addresses that fit the array
  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> ((req_i.addr - soc_pkg::DramBase) >> soc_pkg::ByteOffWidth)
                < soc_pkg::L2NumWords);

endmodule

`default_nettype wire

/* rtl/apb_uart_bridge.sv */
// One APB slave only and byte strobes are dropped so a partial write writes the whole lane
`timescale 1ns/1ps
`default_nettype none

module apb_uart_bridge (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             valid_i,
  output logic                             ready_o,
  output logic                             done_o,
  input  soc_pkg::bus_req_t                req_i,
  output soc_pkg::bus_rsp_t                rsp_o,
  output logic                             uart_psel_o,
  output logic                             uart_penable_o,
  output logic                             uart_pwrite_o,
  output logic [soc_pkg::AddrWidth-1:0]    uart_paddr_o,
  output logic [soc_pkg::ApbDataWidth-1:0] uart_pwdata_o,
  input  logic [soc_pkg::ApbDataWidth-1:0] uart_prdata_i,
  input  logic                             uart_pready_i,
  input  logic                             uart_pslverr_i
);

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e                       state_q;
  apb_state_e                       state_d;
  logic [soc_pkg::AddrWidth-1:0]    paddr_q;
  logic [soc_pkg::ApbDataWidth-1:0] pwdata_q;
  logic                             pwrite_q;
  logic                             done_q;
  soc_pkg::bus_rsp_t                rsp_q;
  logic                             accept;
  logic                             xfer_end;

  assign ready_o  = (state_q == APB_IDLE);
  assign accept   = valid_i && ready_o;
  assign xfer_end = (state_q == APB_ACCESS) && uart_pready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE:   if (valid_i) state_d = APB_SETUP;
      APB_SETUP:  state_d = APB_ACCESS;
      APB_ACCESS: if (uart_pready_i) state_d = APB_IDLE;
      default:    state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= APB_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= xfer_end;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transfer payload

  // Upper lane when address bit 2 is set
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q  <= req_i.addr - soc_pkg::UartBase;
      pwrite_q <= req_i.write;
      pwdata_q <= req_i.addr[soc_pkg::ByteOffWidth-1] ?
                  req_i.wdata[soc_pkg::DataWidth-1 -: soc_pkg::ApbDataWidth] :
                  req_i.wdata[soc_pkg::ApbDataWidth-1:0];
    end
    if (xfer_end)
      rsp_q <= '{rdata: {uart_prdata_i, uart_prdata_i}, err: uart_pslverr_i};
  end

  assign uart_psel_o    = (state_q != APB_IDLE);
  assign uart_penable_o = (state_q == APB_ACCESS);
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;
  assign done_o         = done_q;
  assign rsp_o          = rsp_q;

  // Access only follows a cycle with psel already high
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    uart_penable_o |-> uart_psel_o && $past(uart_psel_o));
  // Address held from setup until the slave completes
  a_paddr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    uart_psel_o && !(uart_penable_o && uart_pready_i) |=> $stable(uart_paddr_o));

endmodule

`default_nettype wire

/* rtl/ctrl_regs.sv */
// Offsets come from the low 12 address bits and the DRAM bound registers are read only
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  output logic                          done_o,
  input  soc_pkg::bus_req_t             req_i,
  output soc_pkg::bus_rsp_t             rsp_o,
  output logic [soc_pkg::DataWidth-1:0] exit_o,
  output logic [soc_pkg::DataWidth-1:0] hw_cnt_en_o
);

  soc_pkg::ctrl_reg_e            reg_sel;
  logic [soc_pkg::DataWidth-1:0] wmask;
  logic [soc_pkg::DataWidth-1:0] rdata_d;
  logic                          err_d;
  logic [soc_pkg::DataWidth-1:0] exit_q;
  logic [soc_pkg::DataWidth-1:0] cnt_en_q;
  logic                          done_q;
  soc_pkg::bus_rsp_t             rsp_q;

  always_comb begin
    for (int b = 0; b < soc_pkg::StrbWidth; b++)
      wmask[8*b +: 8] = {8{req_i.strb[b]}};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register decode

  always_comb begin
    reg_sel = soc_pkg::ctrl_reg_e'(req_i.addr[soc_pkg::RegOffWidth-1:0]);
    rdata_d = '0;
    err_d   = 1'b0;
    case (reg_sel)
      soc_pkg::REG_EXIT:      rdata_d = exit_q;
      soc_pkg::REG_CNT_EN:    rdata_d = cnt_en_q;
      soc_pkg::REG_DRAM_BASE:
        rdata_d = {{(soc_pkg::DataWidth-soc_pkg::AddrWidth){1'b0}}, soc_pkg::DramBase};
      soc_pkg::REG_DRAM_END:
        rdata_d = {{(soc_pkg::DataWidth-soc_pkg::AddrWidth){1'b0}},
                   soc_pkg::DramBase + soc_pkg::DramLength};
      default:                err_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= valid_i;
      if (valid_i && req_i.write) begin
        if (reg_sel == soc_pkg::REG_EXIT)
          exit_q <= (exit_q & ~wmask) | (req_i.wdata & wmask);
        if (reg_sel == soc_pkg::REG_CNT_EN)
          cnt_en_q <= (cnt_en_q & ~wmask) | (req_i.wdata & wmask);
      end
    end
  end

  // Read data is the value before any write in the same access
  always_ff @(posedge clk_i) begin
    if (valid_i)
      rsp_q <= '{rdata: rdata_d, err: err_d};
  end

  assign ready_o     = 1'b1;
  assign done_o      = done_q;
  assign rsp_o       = rsp_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

`default_nettype wire

/* rtl/soc_periph.sv */
// Targets see requests only through the decoder and share one request bus
`timescale 1ns/1ps
`default_nettype none

module soc_periph (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  soc_pkg::bus_req_t                req_i,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output soc_pkg::bus_rsp_t                rsp_o,
  output logic [soc_pkg::DataWidth-1:0]    exit_o,
  output logic [soc_pkg::DataWidth-1:0]    hw_cnt_en_o,
  output logic                             uart_psel_o,
  output logic                             uart_penable_o,
  output logic                             uart_pwrite_o,
  output logic [soc_pkg::AddrWidth-1:0]    uart_paddr_o,
  output logic [soc_pkg::ApbDataWidth-1:0] uart_pwdata_o,
  input  logic [soc_pkg::ApbDataWidth-1:0] uart_prdata_i,
  input  logic                             uart_pready_i,
  input  logic                             uart_pslverr_i
);

  soc_pkg::bus_req_t tgt_req;
  logic              l2_valid, l2_ready, l2_done;
  logic              uart_valid, uart_ready, uart_done;
  logic              ctrl_valid, ctrl_ready, ctrl_done;
  soc_pkg::bus_rsp_t l2_rsp, uart_rsp, ctrl_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder

  soc_addr_decoder i_decoder (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i      ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o      ),
    .tgt_req_o   (tgt_req    ),
    .l2_valid_o  (l2_valid   ),
    .l2_ready_i  (l2_ready   ),
    .l2_done_i   (l2_done    ),
    .l2_rsp_i    (l2_rsp     ),
    .uart_valid_o(uart_valid ),
    .uart_ready_i(uart_ready ),
    .uart_done_i (uart_done  ),
    .uart_rsp_i  (uart_rsp   ),
    .ctrl_valid_o(ctrl_valid ),
    .ctrl_ready_i(ctrl_ready ),
    .ctrl_done_i (ctrl_done  ),
    .ctrl_rsp_i  (ctrl_rsp   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Targets

  l2_mem i_l2_mem (
    .clk_i   (clk_i   ),
    .arst_n_i(arst_n_i),
    .valid_i (l2_valid),
    .ready_o (l2_ready),
    .done_o  (l2_done ),
    .req_i   (tgt_req ),
    .rsp_o   (l2_rsp  )
  );

  apb_uart_bridge i_uart_bridge (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .valid_i       (uart_valid    ),
    .ready_o       (uart_ready    ),
    .done_o        (uart_done     ),
    .req_i         (tgt_req       ),
    .rsp_o         (uart_rsp      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .valid_i    (ctrl_valid ),
    .ready_o    (ctrl_ready ),
    .done_o     (ctrl_done  ),
    .req_i      (tgt_req    ),
    .rsp_o      (ctrl_rsp   ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
// Free-running 8 ns clock with an active-low reset held for the first 10 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int ResetCycles = 10;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_soc_periph.sv */
// Sends one request at a time to a UART model with eight registers at offsets 0x00 to 0x1C
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

  localparam int NumEntries    = 27;
  localparam int TimeoutCycles = NumEntries * 40 + 10;
  localparam logic [31:0] ExitAddr  = 32'hD000_0000;
  localparam logic [31:0] CntEnAddr = 32'hD000_0008;

  typedef struct packed {
    logic [soc_pkg::AddrWidth-1:0] addr;
    logic                          write;
    logic [soc_pkg::DataWidth-1:0] wdata;
    logic [soc_pkg::StrbWidth-1:0] strb;
    logic [soc_pkg::DataWidth-1:0] rdata;
    logic                          err;
    logic                          chk;
    logic [1:0]                    lat;
  } stim_t;

  logic              clk;
  logic              arst_n;
  logic              req_valid;
  logic              req_ready;
  soc_pkg::bus_req_t req;
  logic              rsp_valid;
  logic              rsp_ready;
  soc_pkg::bus_rsp_t rsp;
  logic [63:0]       exit_val;
  logic [63:0]       cnt_en_val;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata = 32'h0;
  logic              pready = 1'b0;
  logic              pslverr = 1'b0;

  stim_t       tbl [NumEntries];
  logic [31:0] lcg_state = 32'd51942;
  logic [31:0] uart_regs [8];
  int          uart_waits = 0;
  int          wait_cnt = 0;
  int          cycle_cnt = 0;

  tb_clk_gen i_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  soc_periph i_dut (
    .clk_i         (clk       ),
    .arst_n_i      (arst_n    ),
    .req_valid_i   (req_valid ),
    .req_ready_o   (req_ready ),
    .req_i         (req       ),
    .rsp_valid_o   (rsp_valid ),
    .rsp_ready_i   (rsp_ready ),
    .rsp_o         (rsp       ),
    .exit_o        (exit_val  ),
    .hw_cnt_en_o   (cnt_en_val),
    .uart_psel_o   (psel      ),
    .uart_penable_o(penable   ),
    .uart_pwrite_o (pwrite    ),
    .uart_paddr_o  (paddr     ),
    .uart_pwdata_o (pwdata    ),
    .uart_prdata_i (prdata    ),
    .uart_pready_i (pready    ),
    .uart_pslverr_i(pslverr   )
  );

  function automatic int next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_val,
                                              input logic [63:0] new_val,
                                              input logic [7:0]  strb);
    logic [63:0] res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (strb[b])
        res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Table columns are addr, write, wdata, strb, rdata, err, check rdata and latency

  task automatic load_table();
    // L2 full and partial strobes
    tbl[0]  = '{32'h8000_0000, 1'b1, 64'h0123_4567_89AB_CDEF, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[1]  = '{32'h8000_0008, 1'b1, 64'h1122_3344_5566_7788, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[2]  = '{32'h8000_0000, 1'b1, 64'hFFEE_DDCC_BBAA_9988, 8'h0F, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[3]  = '{32'h8000_0008, 1'b1, 64'hAAAA_BBBB_CCCC_DDDD, 8'hA5, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[4]  = '{32'h8000_0000, 1'b0, 64'h0, 8'h00, 64'h0123_4567_BBAA_9988, 1'b0, 1'b1, 2'd2};
    tbl[5]  = '{32'h8000_0008, 1'b0, 64'h0, 8'h00, 64'hAA22_BB44_55CC_77DD, 1'b0, 1'b1, 2'd2};
    tbl[6]  = '{32'h8000_0FF8, 1'b1, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[7]  = '{32'h8000_0FF8, 1'b0, 64'h0, 8'h00, 64'hDEAD_BEEF_CAFE_F00D, 1'b0, 1'b1, 2'd2};
    // Control registers
    tbl[8]  = '{32'hD000_0000, 1'b1, 64'h0000_0000_0000_0001, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[9]  = '{32'hD000_0000, 1'b0, 64'h0, 8'h00, 64'h0000_0000_0000_0001, 1'b0, 1'b1, 2'd2};
    tbl[10] = '{32'hD000_0008, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF, 8'h03, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[11] = '{32'hD000_0008, 1'b0, 64'h0, 8'h00, 64'h0000_0000_0000_FFFF, 1'b0, 1'b1, 2'd2};
    tbl[12] = '{32'hD000_0010, 1'b0, 64'h0, 8'h00, 64'h0000_0000_8000_0000, 1'b0, 1'b1, 2'd2};
    tbl[13] = '{32'hD000_0018, 1'b0, 64'h0, 8'h00, 64'h0000_0000_8000_1000, 1'b0, 1'b1, 2'd2};
    tbl[14] = '{32'hD000_0010, 1'b1, 64'h0000_0000_0000_1234, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd2};
    tbl[15] = '{32'hD000_0010, 1'b0, 64'h0, 8'h00, 64'h0000_0000_8000_0000, 1'b0, 1'b1, 2'd2};
    tbl[16] = '{32'hD000_0028, 1'b0, 64'h0, 8'h00, 64'h0, 1'b1, 1'b0, 2'd2};
    // UART lanes with bit 2 picking the upper half
    tbl[17] = '{32'hC000_0000, 1'b1, 64'h1111_2222_3333_4444, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd0};
    tbl[18] = '{32'hC000_0004, 1'b1, 64'h5555_6666_7777_8888, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd0};
    tbl[19] = '{32'hC000_0000, 1'b0, 64'h0, 8'h00, 64'h3333_4444_3333_4444, 1'b0, 1'b1, 2'd0};
    tbl[20] = '{32'hC000_0004, 1'b0, 64'h0, 8'h00, 64'h5555_6666_5555_6666, 1'b0, 1'b1, 2'd0};
    tbl[21] = '{32'hC000_001C, 1'b1, 64'h0BAD_F00D_0000_0000, 8'hFF, 64'h0, 1'b0, 1'b0, 2'd0};
    tbl[22] = '{32'hC000_001C, 1'b0, 64'h0, 8'h00, 64'h0BAD_F00D_0BAD_F00D, 1'b0, 1'b1, 2'd0};
    tbl[23] = '{32'hC000_0040, 1'b0, 64'h0, 8'h00, 64'h0, 1'b1, 1'b0, 2'd0};
    // Unmapped address
    tbl[24] = '{32'h1000_0000, 1'b0, 64'h0, 8'h00, 64'h0, 1'b1, 1'b1, 2'd1};
    tbl[25] = '{32'h1000_0000, 1'b1, 64'h5A5A_5A5A_5A5A_5A5A, 8'hFF, 64'h0, 1'b1, 1'b1, 2'd1};
    tbl[26] = '{32'h8000_0000, 1'b0, 64'h0, 8'h00, 64'h0123_4567_BBAA_9988, 1'b0, 1'b1, 2'd2};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // UART APB slave model

  always @(posedge clk or negedge arst_n) begin : uart_model
    logic ok;
    if (!arst_n) begin
      pready   <= 1'b0;
      pslverr  <= 1'b0;
      prdata   <= 32'h0;
      wait_cnt <= 0;
      for (int r = 0; r < 8; r++)
        uart_regs[r] <= 32'h0;
    end else if (psel && !penable) begin
      ok = (paddr < 32'h20);
      if (ok && pwrite)
        uart_regs[paddr[4:2]] <= pwdata;
      prdata   <= ok ? uart_regs[paddr[4:2]] : 32'h0;
      pslverr  <= !ok;
      wait_cnt <= uart_waits;
      pready   <= (uart_waits == 0);
    end else if (psel && penable) begin
      if (pready) begin
        pready  <= 1'b0;
        pslverr <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 1;
        pready   <= (wait_cnt == 1);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main
    int                n;
    int                stall;
    soc_pkg::bus_rsp_t held;
    logic [63:0]       exit_exp;
    logic [63:0]       cnt_exp;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    exit_exp  = 64'h0;
    cnt_exp   = 64'h0;
    load_table();
    @(posedge arst_n);
    @(negedge clk);
    check_equal(64'(rsp_valid), 64'h0, "rsp_valid after reset");
    check_equal(64'(psel), 64'h0, "uart_psel after reset");
    check_equal(64'(penable), 64'h0, "uart_penable after reset");
    check_equal(exit_val, 64'h0, "exit after reset");
    check_equal(cnt_en_val, 64'h0, "hw_cnt_en after reset");
    for (int i = 0; i < NumEntries; i++) begin
      uart_waits = next_random() % 4;
      stall      = next_random() % 3;
      @(posedge clk);
      req_valid  <= 1'b1;
      req.addr   <= tbl[i].addr;
      req.write  <= tbl[i].write;
      req.wdata  <= tbl[i].wdata;
      req.strb   <= tbl[i].strb;
      @(negedge clk);
      while (!req_ready)
        @(negedge clk);
      // Accept edge
      @(posedge clk);
      req_valid <= 1'b0;
      n = 0;
      do begin
        @(negedge clk);
        n++;
        check_equal(64'(req_ready), 64'h0, $sformatf("entry %0d req_ready while busy", i));
        if (psel) begin
          check_equal(64'(pwrite), 64'(tbl[i].write), $sformatf("entry %0d uart pwrite", i));
          check_equal(64'(paddr), 64'(tbl[i].addr[11:0]), $sformatf("entry %0d uart paddr", i));
        end
      end while (!rsp_valid);
      held = rsp;
      check_equal(64'(rsp.err), 64'(tbl[i].err), $sformatf("entry %0d err", i));
      if (tbl[i].chk)
        check_equal(rsp.rdata, tbl[i].rdata, $sformatf("entry %0d rdata", i));
      if (tbl[i].lat != 2'd0)
        check_equal(64'(n), 64'(tbl[i].lat), $sformatf("entry %0d latency", i));
      // Response held under back-pressure
      repeat (stall) begin
        @(negedge clk);
        check_equal(64'(rsp_valid), 64'h1, $sformatf("entry %0d rsp_valid held", i));
        check_equal(64'(req_ready), 64'h0, $sformatf("entry %0d req_ready held", i));
        check_equal(rsp.rdata, held.rdata, $sformatf("entry %0d rdata held", i));
        check_equal(64'(rsp.err), 64'(held.err), $sformatf("entry %0d err held", i));
      end
      @(posedge clk);
      rsp_ready <= 1'b1;
      @(posedge clk);
      rsp_ready <= 1'b0;
      if (tbl[i].write && tbl[i].addr == ExitAddr)
        exit_exp = merge_bytes(exit_exp, tbl[i].wdata, tbl[i].strb);
      if (tbl[i].write && tbl[i].addr == CntEnAddr)
        cnt_exp = merge_bytes(cnt_exp, tbl[i].wdata, tbl[i].strb);
      @(negedge clk);
      check_equal(64'(rsp_valid), 64'h0, $sformatf("entry %0d rsp_valid after accept", i));
      check_equal(exit_val, exit_exp, $sformatf("entry %0d exit", i));
      check_equal(cnt_en_val, cnt_exp, $sformatf("entry %0d hw_cnt_en", i));
    end
    $display("Applied %0d table entries", NumEntries);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
rtl/soc_pkg.sv
rtl/soc_addr_decoder.sv
rtl/l2_mem.sv
rtl/apb_uart_bridge.sv
rtl/ctrl_regs.sv
rtl/soc_periph.sv
tb/tb_clk_gen.sv
tb/tb_soc_periph.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for a failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_soc_periph \
  -Mdir obj_dir -o tb_soc_periph
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_periph > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

exit 0
